/* flist.f */
design/pkt_format_pkg.sv
design/page_mem_pkg.sv
design/packet_writer.sv
design/page_store.sv
design/packet_reader.sv
design/packet_buffer_top.sv
verification/tb_packet_buffer.sv

/* Bender.yml */
package:
  name: packet_buffer

sources:
  - target: any(rtl, test)
    files:
      - design/pkt_format_pkg.sv
      - design/page_mem_pkg.sv
      - design/packet_writer.sv
      - design/page_store.sv
      - design/packet_reader.sv
      - design/packet_buffer_top.sv
  - target: test
    files:
      - verification/tb_packet_buffer.sv

/* verification/tb_packet_buffer.sv */
`timescale 1ns/1ns

module tb_packet_buffer;

    import pkt_format_pkg::*;
    import page_mem_pkg::*;

    // cycle limit for any single wait
    localparam int TIMEOUT  = 20000;
    localparam int MAX_PKTS = 256;

    logic              clk;
    logic              rst_n;
    logic              wr_sop;
    logic              wr_eop;
    logic              wr_vld;
    pkt_word_u         wr_data;
    logic              full;
    logic              ready;
    logic              rd_sop;
    logic              rd_eop;
    logic              rd_vld;
    logic [WORD_W-1:0] rd_data;

    // words of every sent packet stored back to back
    pkt_word_u words [MAX_PKTS*MAX_PKT_WORDS];
    int        pkt_base [MAX_PKTS];
    int        pkt_len [MAX_PKTS];
    int        pkt_prio [MAX_PKTS];
    // 1 while waiting in its queue and 2 once handed to the reader
    int        pkt_state [MAX_PKTS];
    // packets in expected output order
    int        exp_q [$];

    integer seed;
    int     n_words;
    int     n_sent;
    int     n_recv;
    int     n_disp;
    int     n_err;
    int     n_checks;
    int     rx_idx;
    int     mon_id;
    // free pages and pages still owed to the packet being written
    int     mf;
    int     mr;
    bit     reader_idle;
    bit     rand_ready;
    bit     check_full;
    bit     ready_next;
    // ready as the DUT saw it on the last rising edge
    bit     ready_at_edge;

    packet_buffer_top dut0 (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_sop  (wr_sop),
        .wr_eop  (wr_eop),
        .wr_vld  (wr_vld),
        .wr_data (wr_data),
        .full    (full),
        .ready   (ready),
        .rd_sop  (rd_sop),
        .rd_eop  (rd_eop),
        .rd_vld  (rd_vld),
        .rd_data (rd_data)
    );

    always #2 clk = ~clk;

    task automatic check_word(input pkt_word_u got, input pkt_word_u exp, input string what);
        n_checks++;
        if (got.raw !== exp.raw) begin
            n_err++;
            $display("error %0t: %s got %h expected %h", $time, what, got.raw, exp.raw);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        n_checks++;
        if (got !== exp) begin
            n_err++;
            $display("error %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic report_counts();
        $display("checks %0d, errors %0d, packets sent %0d, received %0d",
                 n_checks, n_err, n_sent, n_recv);
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        report_counts();
        $display("TEST RESULT: FAIL");
        $finish;
    endtask

    // reader picks its next packet
    // mask before dispatch k keeps priorities 0..7-(k mod 8)
    task automatic dispatch_next();
        logic [NUM_PRIO-1:0] pending;
        logic [NUM_PRIO-1:0] allowed;
        int                  sel;
        int                  pick;
        pending = '0;
        for (int i = 0; i < n_sent; i++) begin
            if (pkt_state[i] == 1)
                pending[pkt_prio[i]] = 1'b1;
        end
        if (pending != '0) begin
            allowed = pending & ({NUM_PRIO{1'b1}} >> (n_disp % NUM_PRIO));
            if (allowed == '0)
                allowed = pending;
            sel = 0;
            for (int p = NUM_PRIO - 1; p >= 0; p--) begin
                if (allowed[p])
                    sel = p;
            end
            // oldest packet of that priority
            pick = 0;
            for (int i = n_sent - 1; i >= 0; i--) begin
                if (pkt_state[i] == 1 && pkt_prio[i] == sel)
                    pick = i;
            end
            pkt_state[pick] = 2;
            exp_q.push_back(pick);
            n_disp++;
            reader_idle = 1'b0;
        end
    endtask

    // sends one packet header first with optional idle gaps
    task automatic send_packet(input int len, input int prio, input bit gaps);
        int        id;
        int        t;
        int        w;
        pkt_word_u hdr_word;
        id = n_sent;
        @(posedge clk);
        #1;
        t = 0;
        while (full && t < TIMEOUT) begin
            @(posedge clk);
            #1;
            t++;
        end
        if (full)
            abort_run("timed out waiting for full to drop before a new packet");
        if (check_full)
            check_flag(full, mf < MAX_PKT_PAGES + mr, "full");
        hdr_word          = '0;
        hdr_word.hdr.prio = PRIO_W'(prio);
        hdr_word.hdr.len  = LEN_W'(len);
        pkt_base[id]      = n_words;
        pkt_len[id]       = len;
        pkt_prio[id]      = prio;
        words[n_words]    = hdr_word;
        for (int i = 1; i < len; i++)
            words[n_words+i].raw = WORD_W'($random(seed));
        n_words += len;
        w = 0;
        while (w < len) begin
            if (gaps && ({$random(seed)} % 4 == 0)) begin
                wr_vld = 1'b0;
                wr_sop = 1'b0;
                wr_eop = 1'b0;
            end else begin
                wr_vld  = 1'b1;
                wr_sop  = (w == 0);
                wr_eop  = (w == len - 1);
                wr_data = words[pkt_base[id]+w];
                // page bookkeeping as seen after this word lands
                if (w % PAGE_WORDS == 0)
                    mf--;
                if (w == len - 1)
                    mr = 0;
                else if (w == 0)
                    mr = (len + PAGE_WORDS - 1) / PAGE_WORDS - 1;
                else if (w % PAGE_WORDS == 0)
                    mr--;
                w++;
            end
            @(posedge clk);
            #1;
            if (check_full)
                check_flag(full, mf < MAX_PKT_PAGES + mr, "full");
        end
        wr_vld = 1'b0;
        wr_sop = 1'b0;
        wr_eop = 1'b0;
        pkt_state[id] = 1;
        n_sent++;
        if (reader_idle)
            dispatch_next();
    endtask

    task automatic wait_drain();
        int t;
        t = 0;
        while (n_recv != n_sent && t < TIMEOUT) begin
            @(posedge clk);
            t++;
        end
        if (n_recv != n_sent)
            abort_run("timed out waiting for all packets to come out");
        @(posedge clk);
        #1;
    endtask

    // inputs only move after the edge, so this is the value the DUT sampled
    always @(posedge clk) begin
        ready_at_edge = ready;
    end

    // output words sampled mid-cycle
    always @(negedge clk) begin
        if (rst_n && rd_vld) begin
            // a word out means its read was issued with ready high
            check_flag(ready_at_edge, 1'b1, "ready in the cycle before rd_vld");
            if (exp_q.size() == 0) begin
                n_err++;
                $display("word came out at %0t while no packet was expected", $time);
            end else begin
                mon_id = exp_q[0];
                check_word(rd_data, words[pkt_base[mon_id]+rx_idx], "rd_data");
                check_flag(rd_sop, rx_idx == 0, "rd_sop");
                check_flag(rd_eop, rx_idx == pkt_len[mon_id] - 1, "rd_eop");
                if (rx_idx == pkt_len[mon_id] - 1) begin
                    void'(exp_q.pop_front());
                    rx_idx = 0;
                    n_recv++;
                    // reader free again
                    reader_idle = 1'b1;
                    dispatch_next();
                end else begin
                    rx_idx++;
                end
            end
        end
    end

    // random back-pressure picked on the edge
    always @(posedge clk) begin
        if (rand_ready) begin
            ready_next = $random(seed);
            #1;
            ready = ready_next;
        end
    end

    task automatic test_single_packets();
        int lens [4] = '{1, 8, 9, 64};
        ready = 1'b1;
        for (int i = 0; i < 4; i++) begin
            send_packet(lens[i], {$random(seed)} % NUM_PRIO, 1'b0);
            wait_drain();
        end
    endtask

    task automatic test_priority_order();
        ready = 1'b0;
        // two packets per priority in scattered order
        for (int i = 0; i < 2 * NUM_PRIO; i++)
            send_packet(1 + {$random(seed)} % PAGE_WORDS, (i * 3) % NUM_PRIO, 1'b0);
        repeat (4) @(posedge clk);
        #1;
        ready = 1'b1;
        wait_drain();
    endtask

    task automatic test_back_pressure();
        rand_ready = 1'b1;
        for (int i = 0; i < 6; i++)
            send_packet(1 + {$random(seed)} % 40, 3, 1'b1);
        wait_drain();
        rand_ready = 1'b0;
        @(posedge clk);
        #1;
        ready = 1'b1;
    endtask

    task automatic test_full_flag();
        int n;
        ready      = 1'b0;
        mf         = NUM_PAGES;
        mr         = 0;
        check_full = 1'b1;
        n          = 0;
        while (!full && n < 8) begin
            send_packet(MAX_PKT_WORDS, {$random(seed)} % NUM_PRIO, 1'b0);
            n++;
        end
        check_flag(full, 1'b1, "full after fill");
        check_full = 1'b0;
        ready      = 1'b1;
        wait_drain();
        check_flag(full, 1'b0, "full after drain");
    endtask

    task automatic test_page_recycling();
        ready = 1'b1;
        // one priority keeps the order independent of enqueue timing
        for (int i = 0; i < 24; i++)
            send_packet(1 + {$random(seed)} % MAX_PKT_WORDS, 6, 1'b0);
        wait_drain();
    endtask

    initial begin
        seed        = 86768;
        clk         = 1'b0;
        rst_n       = 1'b0;
        wr_sop      = 1'b0;
        wr_eop      = 1'b0;
        wr_vld      = 1'b0;
        wr_data     = '0;
        ready       = 1'b0;
        n_words     = 0;
        n_sent      = 0;
        n_recv      = 0;
        n_disp      = 0;
        n_err       = 0;
        n_checks    = 0;
        rx_idx      = 0;
        mf          = NUM_PAGES;
        mr          = 0;
        reader_idle = 1'b1;
        rand_ready  = 1'b0;
        check_full  = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        test_single_packets();
        test_priority_order();
        test_back_pressure();
        test_full_flag();
        test_page_recycling();
        report_counts();
        if (n_err == 0 && n_recv == n_sent) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* design/packet_buffer_top.sv */
`timescale 1ns/1ns

module packet_buffer_top (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              wr_sop,
    input  logic                              wr_eop,
    input  logic                              wr_vld,
    input  pkt_format_pkg::pkt_word_u         wr_data,
    output logic                              full,
    input  logic                              ready,
    output logic                              rd_sop,
    output logic                              rd_eop,
    output logic                              rd_vld,
    output logic [pkt_format_pkg::WORD_W-1:0] rd_data
);

    import pkt_format_pkg::*;
    import page_mem_pkg::*;

    // writer side
    logic                alloc_en;
    logic [CNT_W-1:0]    reserve_pages;
    logic                mem_wr_en;
    logic [ADDR_W-1:0]   mem_wr_addr;
    logic [WORD_W-1:0]   mem_wr_data;
    logic                link_en;
    logic [PAGE_W-1:0]   link_from;
    logic [PAGE_W-1:0]   link_to;
    logic                enq_en;
    logic [PRIO_W-1:0]   enq_prio;
    logic [PAGE_W-1:0]   enq_head;
    logic [PAGE_W-1:0]   free_head;

    // reader side
    logic [NUM_PRIO-1:0]             q_nonempty;
    logic [NUM_PRIO-1:0][PAGE_W-1:0] q_head;
    logic                            deq_en;
    logic [PRIO_W-1:0]               deq_prio;
    logic                            mem_rd_en;
    logic [ADDR_W-1:0]               mem_rd_addr;
    pkt_word_u                       mem_rd_data;
    logic [PAGE_W-1:0]               jt_page;
    logic [PAGE_W-1:0]               jt_next;
    logic                            free_en;
    logic [PAGE_W-1:0]               free_page;

    packet_writer writer0 (
        .clk           (clk),
        .rst_n         (rst_n),
        .wr_sop        (wr_sop),
        .wr_eop        (wr_eop),
        .wr_vld        (wr_vld),
        .wr_data       (wr_data),
        .free_head     (free_head),
        .alloc_en      (alloc_en),
        .reserve_pages (reserve_pages),
        .mem_wr_en     (mem_wr_en),
        .mem_wr_addr   (mem_wr_addr),
        .mem_wr_data   (mem_wr_data),
        .link_en       (link_en),
        .link_from     (link_from),
        .link_to       (link_to),
        .enq_en        (enq_en),
        .enq_prio      (enq_prio),
        .enq_head      (enq_head)
    );

    page_store store0 (
        .clk           (clk),
        .rst_n         (rst_n),
        .alloc_en      (alloc_en),
        .reserve_pages (reserve_pages),
        .mem_wr_en     (mem_wr_en),
        .mem_wr_addr   (mem_wr_addr),
        .mem_wr_data   (mem_wr_data),
        .link_en       (link_en),
        .link_from     (link_from),
        .link_to       (link_to),
        .enq_en        (enq_en),
        .enq_prio      (enq_prio),
        .enq_head      (enq_head),
        .deq_en        (deq_en),
        .deq_prio      (deq_prio),
        .mem_rd_en     (mem_rd_en),
        .mem_rd_addr   (mem_rd_addr),
        .jt_page       (jt_page),
        .free_en       (free_en),
        .free_page     (free_page),
        .free_head     (free_head),
        .full          (full),
        .q_nonempty    (q_nonempty),
        .q_head        (q_head),
        .mem_rd_data   (mem_rd_data),
        .jt_next       (jt_next)
    );

    packet_reader reader0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .ready       (ready),
        .q_nonempty  (q_nonempty),
        .q_head      (q_head),
        .mem_rd_data (mem_rd_data),
        .jt_next     (jt_next),
        .deq_en      (deq_en),
        .deq_prio    (deq_prio),
        .mem_rd_en   (mem_rd_en),
        .mem_rd_addr (mem_rd_addr),
        .jt_page     (jt_page),
        .free_en     (free_en),
        .free_page   (free_page),
        .rd_sop      (rd_sop),
        .rd_eop      (rd_eop),
        .rd_vld      (rd_vld),
        .rd_data     (rd_data)
    );

endmodule

/* design/packet_reader.sv */
`timescale 1ns/1ns

module packet_reader (
    input  logic                                                         clk,
    input  logic                                                         rst_n,
    input  logic                                                         ready,
    input  logic [pkt_format_pkg::NUM_PRIO-1:0]                          q_nonempty,
    input  logic [pkt_format_pkg::NUM_PRIO-1:0][page_mem_pkg::PAGE_W-1:0] q_head,
    input  pkt_format_pkg::pkt_word_u                                    mem_rd_data,
    input  logic [page_mem_pkg::PAGE_W-1:0]                              jt_next,
    output logic                                                         deq_en,
    output logic [pkt_format_pkg::PRIO_W-1:0]                            deq_prio,
    output logic                                                         mem_rd_en,
    output logic [page_mem_pkg::ADDR_W-1:0]                              mem_rd_addr,
    output logic [page_mem_pkg::PAGE_W-1:0]                              jt_page,
    output logic                                                         free_en,
    output logic [page_mem_pkg::PAGE_W-1:0]                              free_page,
    output logic                                                         rd_sop,
    output logic                                                         rd_eop,
    output logic                                                         rd_vld,
    output logic [pkt_format_pkg::WORD_W-1:0]                            rd_data
);

    import pkt_format_pkg::*;
    import page_mem_pkg::*;

    logic                busy;
    logic                need_hdr;
    logic                hdr_issued;
    logic                last_q;
    logic [NUM_PRIO-1:0] wrr_mask;
    logic [NUM_PRIO-1:0] cand;
    logic [NUM_PRIO-1:0] mask_next;
    logic [PAGE_W-1:0]   cur_page;
    logic [OFFS_W-1:0]   offs;
    logic [LEN_W-1:0]    left;
    logic [LEN_W-1:0]    left_now;
    logic                last_word;
    logic                hdr_only;
    logic                pkt_done;

    // shrinking-mask round robin
    always_comb begin
        cand = q_nonempty & wrr_mask;
        // fall back to plain priority when mask hides all requesters
        if (cand == '0)
            cand = q_nonempty;
        deq_prio = '0;
        for (int i = NUM_PRIO - 1; i >= 0; i--) begin
            if (cand[i])
                deq_prio = PRIO_W'(i);
        end
        // drop the highest set mask bit
        mask_next = wrr_mask;
        for (int i = 0; i < NUM_PRIO; i++) begin
            if (wrr_mask[i])
                mask_next = wrr_mask & ~(NUM_PRIO'(1) << i);
        end
        if (mask_next == '0)
            mask_next = '1;
    end

    assign deq_en = !busy && (q_nonempty != '0);

    // word count is only known once the header comes back
    assign left_now  = hdr_issued ? mem_rd_data.hdr.len - LEN_W'(1) : left;
    assign mem_rd_en = busy && ready && (need_hdr || left_now != '0);
    assign last_word = !need_hdr && (left_now == LEN_W'(1));
    // one-word packet, header was the whole thing
    assign hdr_only  = hdr_issued && (left_now == '0);
    assign pkt_done  = (mem_rd_en && last_word) || hdr_only;

    assign mem_rd_addr = {cur_page, offs};
    assign jt_page     = cur_page;

    // page goes back after its last read is issued
    assign free_en   = (mem_rd_en && (offs == OFFS_W'(PAGE_WORDS - 1) || last_word)) || hdr_only;
    assign free_page = cur_page;

    // output framing
    assign rd_data = mem_rd_data.raw;
    assign rd_eop  = rd_vld && (rd_sop ? (mem_rd_data.hdr.len == LEN_W'(1)) : last_q);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy       <= 1'b0;
            need_hdr   <= 1'b0;
            hdr_issued <= 1'b0;
            last_q     <= 1'b0;
            wrr_mask   <= '1;
            offs       <= '0;
            left       <= '0;
            rd_vld     <= 1'b0;
            rd_sop     <= 1'b0;
        end else begin
            hdr_issued <= mem_rd_en && need_hdr;
            rd_vld     <= mem_rd_en;
            rd_sop     <= mem_rd_en && need_hdr;
            if (mem_rd_en)
                last_q <= last_word;
            if (deq_en) begin
                // dispatch, header read comes next
                busy     <= 1'b1;
                need_hdr <= 1'b1;
                offs     <= '0;
                wrr_mask <= mask_next;
            end else if (busy) begin
                if (mem_rd_en) begin
                    need_hdr <= 1'b0;
                    offs     <= offs + OFFS_W'(1);
                end
                if (!need_hdr)
                    left <= left_now - LEN_W'(mem_rd_en);
                if (pkt_done)
                    busy <= 1'b0;
            end
        end
    end

    // page walk through the jump table
    always_ff @(posedge clk) begin
        if (deq_en)
            cur_page <= q_head[deq_prio];
        else if (mem_rd_en && offs == OFFS_W'(PAGE_WORDS - 1))
            cur_page <= jt_next;
    end

endmodule

/* design/page_store.sv */
`timescale 1ns/1ns

module page_store (
    input  logic                                                         clk,
    input  logic                                                         rst_n,
    input  logic                                                         alloc_en,
    input  logic [page_mem_pkg::CNT_W-1:0]                               reserve_pages,
    input  logic                                                         mem_wr_en,
    input  logic [page_mem_pkg::ADDR_W-1:0]                              mem_wr_addr,
    input  logic [pkt_format_pkg::WORD_W-1:0]                            mem_wr_data,
    input  logic                                                         link_en,
    input  logic [page_mem_pkg::PAGE_W-1:0]                              link_from,
    input  logic [page_mem_pkg::PAGE_W-1:0]                              link_to,
    input  logic                                                         enq_en,
    input  logic [pkt_format_pkg::PRIO_W-1:0]                            enq_prio,
    input  logic [page_mem_pkg::PAGE_W-1:0]                              enq_head,
    input  logic                                                         deq_en,
    input  logic [pkt_format_pkg::PRIO_W-1:0]                            deq_prio,
    input  logic                                                         mem_rd_en,
    input  logic [page_mem_pkg::ADDR_W-1:0]                              mem_rd_addr,
    input  logic [page_mem_pkg::PAGE_W-1:0]                              jt_page,
    input  logic                                                         free_en,
    input  logic [page_mem_pkg::PAGE_W-1:0]                              free_page,
    output logic [page_mem_pkg::PAGE_W-1:0]                              free_head,
    output logic                                                         full,
    output logic [pkt_format_pkg::NUM_PRIO-1:0]                          q_nonempty,
    output logic [pkt_format_pkg::NUM_PRIO-1:0][page_mem_pkg::PAGE_W-1:0] q_head,
    output logic [pkt_format_pkg::WORD_W-1:0]                            mem_rd_data,
    output logic [page_mem_pkg::PAGE_W-1:0]                              jt_next
);

    import pkt_format_pkg::*;
    import page_mem_pkg::*;

    logic [WORD_W-1:0] data_mem [NUM_PAGES*PAGE_WORDS];
    logic [PAGE_W-1:0] jump_tbl [NUM_PAGES];

    // circular list of free page numbers
    logic [PAGE_W-1:0] free_list [NUM_PAGES];
    logic [PAGE_W-1:0] fl_rd_ptr;
    logic [PAGE_W-1:0] fl_wr_ptr;
    logic [CNT_W-1:0]  fl_cnt;

    // per-priority queues of head pages, pointers wrap at QDEPTH
    logic [PAGE_W-1:0]   q_mem [NUM_PRIO][QDEPTH];
    logic [PAGE_W-1:0]   q_rd_ptr [NUM_PRIO];
    logic [PAGE_W-1:0]   q_wr_ptr [NUM_PRIO];
    logic [CNT_W-1:0]    q_cnt [NUM_PRIO];
    logic [NUM_PRIO-1:0] enq_sel;
    logic [NUM_PRIO-1:0] deq_sel;

    // data memory, read data one cycle after request
    always_ff @(posedge clk) begin
        if (mem_wr_en)
            data_mem[mem_wr_addr] <= mem_wr_data;
        if (mem_rd_en)
            mem_rd_data <= data_mem[mem_rd_addr];
    end

    // next-page links
    always_ff @(posedge clk) begin
        if (link_en)
            jump_tbl[link_from] <= link_to;
    end

    assign jt_next = jump_tbl[jt_page];

    // free list starts holding every page
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fl_rd_ptr <= '0;
            fl_wr_ptr <= '0;
            fl_cnt    <= CNT_W'(NUM_PAGES);
            for (int i = 0; i < NUM_PAGES; i++)
                free_list[i] <= PAGE_W'(i);
        end else begin
            if (alloc_en)
                fl_rd_ptr <= fl_rd_ptr + PAGE_W'(1);
            if (free_en) begin
                free_list[fl_wr_ptr] <= free_page;
                fl_wr_ptr            <= fl_wr_ptr + PAGE_W'(1);
            end
            // pop and push together cancel out
            if (alloc_en && !free_en)
                fl_cnt <= fl_cnt - CNT_W'(1);
            else if (free_en && !alloc_en)
                fl_cnt <= fl_cnt + CNT_W'(1);
        end
    end

    assign free_head = free_list[fl_rd_ptr];

    // room for one max packet beyond what the current writer still needs
    assign full = fl_cnt < (CNT_W'(MAX_PKT_PAGES) + reserve_pages);

    // one-hot queue strobes
    assign enq_sel = enq_en ? (NUM_PRIO'(1) << enq_prio) : '0;
    assign deq_sel = deq_en ? (NUM_PRIO'(1) << deq_prio) : '0;

    always_ff @(posedge clk) begin
        if (enq_en)
            q_mem[enq_prio][q_wr_ptr[enq_prio]] <= enq_head;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int p = 0; p < NUM_PRIO; p++) begin
                q_rd_ptr[p] <= '0;
                q_wr_ptr[p] <= '0;
                q_cnt[p]    <= '0;
            end
        end else begin
            for (int p = 0; p < NUM_PRIO; p++) begin
                if (enq_sel[p])
                    q_wr_ptr[p] <= q_wr_ptr[p] + PAGE_W'(1);
                if (deq_sel[p])
                    q_rd_ptr[p] <= q_rd_ptr[p] + PAGE_W'(1);
                case ({enq_sel[p], deq_sel[p]})
                    2'b10:   q_cnt[p] <= q_cnt[p] + CNT_W'(1);
                    2'b01:   q_cnt[p] <= q_cnt[p] - CNT_W'(1);
                    default: q_cnt[p] <= q_cnt[p];
                endcase
            end
        end
    end

    // head of every queue, visible to the reader
    always_comb begin
        for (int p = 0; p < NUM_PRIO; p++) begin
            q_head[p]     = q_mem[p][q_rd_ptr[p]];
            q_nonempty[p] = q_cnt[p] != '0;
        end
    end

endmodule

/* design/packet_writer.sv */
`timescale 1ns/1ns

module packet_writer (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                wr_sop,
    input  logic                                wr_eop,
    input  logic                                wr_vld,
    input  pkt_format_pkg::pkt_word_u           wr_data,
    input  logic [page_mem_pkg::PAGE_W-1:0]     free_head,
    output logic                                alloc_en,
    output logic [page_mem_pkg::CNT_W-1:0]      reserve_pages,
    output logic                                mem_wr_en,
    output logic [page_mem_pkg::ADDR_W-1:0]     mem_wr_addr,
    output logic [pkt_format_pkg::WORD_W-1:0]   mem_wr_data,
    output logic                                link_en,
    output logic [page_mem_pkg::PAGE_W-1:0]     link_from,
    output logic [page_mem_pkg::PAGE_W-1:0]     link_to,
    output logic                                enq_en,
    output logic [pkt_format_pkg::PRIO_W-1:0]   enq_prio,
    output logic [page_mem_pkg::PAGE_W-1:0]     enq_head
);

    import pkt_format_pkg::*;
    import page_mem_pkg::*;

    logic [OFFS_W-1:0] offs;
    logic [PAGE_W-1:0] cur_page;
    logic [PAGE_W-1:0] head_page;
    logic [PRIO_W-1:0] prio;
    logic [CNT_W-1:0]  rem_pages;
    logic [CNT_W-1:0]  need_pages;
    logic              new_page;

    // pages for the whole packet, rounded up
    assign need_pages = CNT_W'((wr_data.hdr.len + LEN_W'(PAGE_WORDS - 1)) >> OFFS_W);

    // a fresh page is taken on offset zero
    assign new_page = wr_vld && (offs == '0);
    assign alloc_en = new_page;

    // the word at offset zero goes straight into the page just popped
    assign mem_wr_en   = wr_vld;
    assign mem_wr_addr = {(offs == '0) ? free_head : cur_page, offs};
    assign mem_wr_data = wr_data.raw;

    // chain previous page to the new one, except for the head page
    assign link_en   = new_page && !wr_sop;
    assign link_from = cur_page;
    assign link_to   = free_head;

    // pages still owed to the packet in progress
    assign reserve_pages = rem_pages;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            offs      <= '0;
            rem_pages <= '0;
            enq_en    <= 1'b0;
        end else begin
            // enqueue one cycle after eop
            enq_en <= wr_vld && wr_eop;
            if (wr_vld) begin
                // offset restarts with each packet
                offs <= wr_eop ? '0 : offs + OFFS_W'(1);
                if (wr_eop)
                    rem_pages <= '0;
                else if (wr_sop)
                    rem_pages <= need_pages - CNT_W'(1);
                else if (offs == '0)
                    rem_pages <= rem_pages - CNT_W'(1);
            end
        end
    end

    // packet context
    always_ff @(posedge clk) begin
        if (new_page)
            cur_page <= free_head;
        if (wr_vld && wr_sop) begin
            head_page <= free_head;
            prio      <= wr_data.hdr.prio;
        end
        // single-word packets take head and prio from the live word
        if (wr_vld && wr_eop) begin
            enq_head <= wr_sop ? free_head : head_page;
            enq_prio <= wr_sop ? wr_data.hdr.prio : prio;
        end
    end

endmodule

/* design/page_mem_pkg.sv */
package page_mem_pkg;

    // words per page and the offset inside a page
    localparam int PAGE_WORDS = 8;
    localparam int OFFS_W = 3;

    // shared page pool
    localparam int NUM_PAGES = 32;
    localparam int PAGE_W = 5;

    // address is {page, offset}
    localparam int ADDR_W = PAGE_W + OFFS_W;

    // largest packet, in words and pages
    localparam int MAX_PKT_WORDS = 64;
    localparam int MAX_PKT_PAGES = MAX_PKT_WORDS / PAGE_WORDS;

    // one slot per page, so no queue can overflow
    localparam int QDEPTH = NUM_PAGES;

    // free count and queue counts, 0..32
    localparam int CNT_W = 6;

endpackage

/* design/pkt_format_pkg.sv */
package pkt_format_pkg;

    // one bus word
    localparam int WORD_W = 16;

    // header field widths
    localparam int PRIO_W = 3;
    localparam int NUM_PRIO = 1 << PRIO_W;
    localparam int LEN_W = 9;

    // upper bits left over once prio and len are placed
    localparam int RSVD_W = WORD_W - PRIO_W - LEN_W;

    // first word of every packet
    // len counts all words, header included
    typedef struct packed {
        logic [RSVD_W-1:0] rsvd;
        logic [PRIO_W-1:0] prio;
        logic [LEN_W-1:0]  len;
    } pkt_header_t;

    // header word read as fields, payload words read raw
    typedef union packed {
        logic [WORD_W-1:0] raw;
        pkt_header_t       hdr;
    } pkt_word_u;

endpackage
